// File: Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = cpuTb
FILELIST = compile.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_MSG = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
+incdir+include
hdl/cpuPkg.sv
hdl/cpuBuses.sv
hdl/hostPort.sv
hdl/instrFetch.sv
hdl/instrDecode.sv
hdl/execUnit.sv
hdl/regFile.sv
hdl/cpuTop.sv
verification/apbSlave_checker.sv
verification/cpuTb.sv

// File: hdl/cpuBuses.sv
/* stage-to-stage buses: execBus from decode into execute, and resultBus from execute
   back to decode for forwarding and on to the register file */
`default_nettype none

interface execBus;
	import cpuPkg::*;

	logic valid;
	aluOpE aluOp;
	logic [DataWidth-1:0] operandA; // rs value after forwarding
	logic [DataWidth-1:0] operandB; // rt value after forwarding
	logic [DataWidth-1:0] imm; // already extended
	logic useImm;
	logic [RegAddrWidth-1:0] shamt;
	logic [RegAddrWidth-1:0] dest;

	modport src (output valid, aluOp, operandA, operandB, imm, useImm, shamt, dest);
	modport dst (input valid, aluOp, operandA, operandB, imm, useImm, shamt, dest);
endinterface

interface resultBus;
	import cpuPkg::*;

	// execute stage, combinational
	logic exValid;
	logic [RegAddrWidth-1:0] exDest;
	logic [DataWidth-1:0] exValue;
	// writeback register
	logic wbValid;
	logic [RegAddrWidth-1:0] wbDest;
	logic [DataWidth-1:0] wbValue;

	modport src (output exValid, exDest, exValue, wbValid, wbDest, wbValue);
	modport fwd (input exValid, exDest, exValue, wbValid, wbDest, wbValue);
	modport wb (input wbValid, wbDest, wbValue);
endinterface

`default_nettype wire

// File: hdl/cpuPkg.sv
/* widths, instruction fields, APB address map and enums for the four-stage pipeline
   modules import it in their bodies and use scoped names for port widths */
`default_nettype none

package cpuPkg;

	localparam int DataWidth = 32;
	localparam int RegAddrWidth = 5;
	localparam int PcWidth = 5; // 32 instruction words
	localparam int ConstWidth = 15;

	// instruction fields, bit 25 unused
	localparam int OpcodeMsb = 31;
	localparam int OpcodeLsb = 26;
	localparam int RsLsb = 20; // doubles as shift amount
	localparam int RtLsb = 15;
	localparam int RdLsb = 10;

	localparam int PipeDepth = 3; // decode, execute, writeback
	localparam int DrainWidth = $clog2(PipeDepth);

	// APB map, byte addresses with one word every 4 bytes
	localparam int ApbAddrWidth = 9;
	localparam int WindowLsb = PcWidth + 2; // both windows are 32 words
	localparam logic [ApbAddrWidth-1:0] ImemBase = 9'h000;
	localparam logic [ApbAddrWidth-1:0] RegBase = 9'h080; // read only
	localparam logic [ApbAddrWidth-1:0] CtrlAddr = 9'h100; // bit0 starts a run
	localparam logic [ApbAddrWidth-1:0] StatusAddr = 9'h104; // bit0 running, bit1 halted

	typedef enum logic [OpcodeMsb-OpcodeLsb:0] {
		opNop = 0, // blank word, fetch holds here
		opAdd,
		opSub,
		opAnd,
		opOr,
		opXor,
		opSlt,
		opShl, // rt shifted by the rs field
		opShr,
		opAddi, // writes rt
		opOri,
		opLui
	} opcodeE;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluShl,
		aluShr,
		aluLui
	} aluOpE;

	typedef enum logic [1:0] {
		stIdle,
		stRunning,
		stDraining, // fetch idle, pipeline still emptying
		stHalted
	} runStateE;

endpackage

`default_nettype wire

// File: hdl/cpuTop.sv
/* top level of the pipeline, APB3 slave ports only
   host loads a program, writes CTRL, polls STATUS and reads back registers */
`default_nettype none

module cpuTop (
	input logic clk,
	input logic arstN,
	input logic [cpuPkg::ApbAddrWidth-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [cpuPkg::DataWidth-1:0] pwdata,
	output logic [cpuPkg::DataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	import cpuPkg::*;

	// host to fetch
	logic imemWe;
	logic [PcWidth-1:0] imemAddr;
	logic [DataWidth-1:0] imemData;
	logic start;
	logic fetchIdle;
	// host register readback
	logic [RegAddrWidth-1:0] hostRegAddr;
	logic [DataWidth-1:0] hostRegData;
	// fetch/decode stage
	logic [DataWidth-1:0] instr;
	logic instrValid;
	// decode read ports
	logic [RegAddrWidth-1:0] rsAddr;
	logic [RegAddrWidth-1:0] rtAddr;
	logic [DataWidth-1:0] rsData;
	logic [DataWidth-1:0] rtData;

	execBus exBus ();
	resultBus resBus ();

	hostPort uHost (
		.clk(clk), .arstN(arstN),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData), .start(start),
		.fetchIdle(fetchIdle), .hostRegAddr(hostRegAddr), .hostRegData(hostRegData)
	);

	instrFetch uFetch (
		.clk(clk), .arstN(arstN),
		.imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData), .start(start),
		.fetchIdle(fetchIdle), .instr(instr), .instrValid(instrValid)
	);

	instrDecode uDecode (
		.clk(clk), .arstN(arstN), .instr(instr), .instrValid(instrValid),
		.rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
		.res(resBus), .ex(exBus)
	);

	execUnit uExec (.clk(clk), .arstN(arstN), .ex(exBus), .res(resBus));

	regFile uRegs (
		.clk(clk), .arstN(arstN),
		.rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
		.hostRegAddr(hostRegAddr), .hostRegData(hostRegData), .res(resBus)
	);

endmodule

`default_nettype wire

// File: hdl/execUnit.sv
/* execute stage: operand B select, ALU and shifter, then the execute/writeback register
   both the combinational result and the registered one go out on resultBus */
`default_nettype none

module execUnit (
	input logic clk,
	input logic arstN,
	execBus.dst ex,
	resultBus.src res
);
	import cpuPkg::*;

	logic [DataWidth-1:0] opB;
	logic [DataWidth-1:0] result;

	assign opB = ex.useImm ? ex.imm : ex.operandB;

	always_comb begin
		case (ex.aluOp)
			aluAdd: result = ex.operandA + opB;
			aluSub: result = ex.operandA - opB;
			aluAnd: result = ex.operandA & opB;
			aluOr: result = ex.operandA | opB;
			aluXor: result = ex.operandA ^ opB;
			aluSlt: result = {{(DataWidth-1){1'b0}}, $signed(ex.operandA) < $signed(opB)};
			aluShl: result = ex.operandB << ex.shamt; // shifts act on rt
			aluShr: result = ex.operandB >> ex.shamt;
			aluLui: result = ex.imm;
			default: result = '0;
		endcase
	end

	// execute stage result for forwarding
	assign res.exValid = ex.valid;
	assign res.exDest = ex.dest;
	assign res.exValue = result;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			res.wbValid <= 1'b0;
		else
			res.wbValid <= ex.valid;
	end

	always_ff @(posedge clk) begin
		res.wbDest <= ex.dest;
		res.wbValue <= result;
	end

endmodule

`default_nettype wire

// File: hdl/hostPort.sv
/* APB3 slave for program load, run control, status and register readback
   every transfer is setup plus one access cycle, pready never drops */
`default_nettype none

module hostPort (
	input logic clk,
	input logic arstN,
	input logic [cpuPkg::ApbAddrWidth-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [cpuPkg::DataWidth-1:0] pwdata,
	output logic [cpuPkg::DataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic imemWe,
	output logic [cpuPkg::PcWidth-1:0] imemAddr,
	output logic [cpuPkg::DataWidth-1:0] imemData,
	output logic start,
	input logic fetchIdle,
	output logic [cpuPkg::RegAddrWidth-1:0] hostRegAddr,
	input logic [cpuPkg::DataWidth-1:0] hostRegData
);
	import cpuPkg::*;

	runStateE state;
	logic [DrainWidth-1:0] drainCnt;
	logic access;
	logic inImem;
	logic inRegs;
	logic isCtrl;
	logic isStatus;
	logic loadable; // pipeline is quiet
	logic running;

	assign access = psel & penable;
	assign inImem = paddr[ApbAddrWidth-1:WindowLsb] == ImemBase[ApbAddrWidth-1:WindowLsb];
	assign inRegs = paddr[ApbAddrWidth-1:WindowLsb] == RegBase[ApbAddrWidth-1:WindowLsb];
	assign isCtrl = paddr == CtrlAddr;
	assign isStatus = paddr == StatusAddr;
	assign loadable = (state == stIdle) | (state == stHalted);
	assign running = (state == stRunning) | (state == stDraining);

	assign pready = 1'b1;
	assign pslverr = access & ((pwrite & inRegs) | (pwrite & inImem & ~loadable)
		| ~(inImem | inRegs | isCtrl | isStatus));

	assign imemWe = access & pwrite & inImem & loadable;
	assign imemAddr = paddr[PcWidth+1:2];
	assign imemData = pwdata;
	assign start = access & pwrite & isCtrl & pwdata[0] & loadable; // ignored while busy
	assign hostRegAddr = paddr[RegAddrWidth+1:2];

	always_comb begin
		prdata = '0;
		if (inRegs)
			prdata = hostRegData;
		else if (isStatus)
			prdata = {{(DataWidth-2){1'b0}}, state == stHalted, running};
	end

	// run control, drain counts the stages behind fetch
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= stIdle;
			drainCnt <= '0;
		end else begin
			case (state)
				stIdle, stHalted: begin
					if (start)
						state <= stRunning;
				end
				stRunning: begin
					if (fetchIdle) begin
						state <= stDraining;
						drainCnt <= '0;
					end
				end
				stDraining: begin
					if (drainCnt == DrainWidth'(PipeDepth - 1))
						state <= stHalted;
					else
						drainCnt <= drainCnt + 1'b1;
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/instrDecode.sv
/* decode stage: field split, opcode decode, operand forwarding and the decode/execute
   register that drives execBus */
`default_nettype none

module instrDecode (
	input logic clk,
	input logic arstN,
	input logic [cpuPkg::DataWidth-1:0] instr,
	input logic instrValid,
	output logic [cpuPkg::RegAddrWidth-1:0] rsAddr,
	output logic [cpuPkg::RegAddrWidth-1:0] rtAddr,
	input logic [cpuPkg::DataWidth-1:0] rsData,
	input logic [cpuPkg::DataWidth-1:0] rtData,
	resultBus.fwd res,
	execBus.src ex
);
	import cpuPkg::*;

	opcodeE opcode;
	logic [RegAddrWidth-1:0] rdAddr;
	logic [ConstWidth-1:0] constant;
	aluOpE aluOpD;
	logic useImmD;
	logic legalD;
	logic [RegAddrWidth-1:0] destD;
	logic [DataWidth-1:0] immD;
	logic [DataWidth-1:0] rsFwd;
	logic [DataWidth-1:0] rtFwd;

	// youngest result wins: execute, then writeback, then the register file
	function automatic logic [DataWidth-1:0] fwdSelect(
		input logic [RegAddrWidth-1:0] addr,
		input logic [DataWidth-1:0] regValue
	);
		if (res.exValid && res.exDest == addr)
			return res.exValue;
		else if (res.wbValid && res.wbDest == addr)
			return res.wbValue;
		return regValue;
	endfunction

	assign opcode = opcodeE'(instr[OpcodeMsb:OpcodeLsb]);
	assign rsAddr = instr[RsLsb +: RegAddrWidth];
	assign rtAddr = instr[RtLsb +: RegAddrWidth];
	assign rdAddr = instr[RdLsb +: RegAddrWidth];
	assign constant = instr[ConstWidth-1:0];
	assign rsFwd = fwdSelect(rsAddr, rsData);
	assign rtFwd = fwdSelect(rtAddr, rtData);

	always_comb begin
		aluOpD = aluAdd;
		useImmD = 1'b0;
		destD = rdAddr;
		immD = '0;
		legalD = 1'b1;
		case (opcode)
			opAdd: aluOpD = aluAdd;
			opSub: aluOpD = aluSub;
			opAnd: aluOpD = aluAnd;
			opOr: aluOpD = aluOr;
			opXor: aluOpD = aluXor;
			opSlt: aluOpD = aluSlt;
			opShl: aluOpD = aluShl;
			opShr: aluOpD = aluShr;
			opAddi: begin
				useImmD = 1'b1;
				destD = rtAddr;
				immD = {{(DataWidth-ConstWidth){constant[ConstWidth-1]}}, constant};
			end
			opOri: begin
				aluOpD = aluOr;
				useImmD = 1'b1;
				destD = rtAddr;
				immD = {{(DataWidth-ConstWidth){1'b0}}, constant}; // zero extend
			end
			opLui: begin
				aluOpD = aluLui;
				useImmD = 1'b1;
				destD = rtAddr;
				immD = {constant, {(DataWidth-ConstWidth){1'b0}}};
			end
			default: legalD = 1'b0; // blank and unused codes become bubbles
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			ex.valid <= 1'b0;
		else
			ex.valid <= instrValid & legalD;
	end

	always_ff @(posedge clk) begin
		ex.aluOp <= aluOpD;
		ex.operandA <= rsFwd;
		ex.operandB <= rtFwd;
		ex.imm <= immD;
		ex.useImm <= useImmD;
		ex.shamt <= rsAddr; // rs field is the shift amount
		ex.dest <= destD;
	end

endmodule

`default_nettype wire

// File: hdl/instrFetch.sv
/* instruction memory loaded by the host, program counter and fetch/decode register
   pc restarts at zero on start and parks on the first blank word */
`default_nettype none

module instrFetch (
	input logic clk,
	input logic arstN,
	input logic imemWe,
	input logic [cpuPkg::PcWidth-1:0] imemAddr,
	input logic [cpuPkg::DataWidth-1:0] imemData,
	input logic start,
	output logic fetchIdle,
	output logic [cpuPkg::DataWidth-1:0] instr,
	output logic instrValid
);
	import cpuPkg::*;

	logic [DataWidth-1:0] imem [2**PcWidth];
	logic [PcWidth-1:0] pc;
	logic running;
	logic [DataWidth-1:0] fetched;
	logic blank;

	assign fetched = imem[pc];
	assign blank = ~(|fetched); // all-zero word ends the program

	always_ff @(posedge clk) begin
		if (imemWe)
			imem[imemAddr] <= imemData;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			running <= 1'b0;
			fetchIdle <= 1'b0;
		end else if (start) begin
			pc <= '0;
			running <= 1'b1;
			fetchIdle <= 1'b0;
		end else if (running) begin
			if (blank) begin
				running <= 1'b0; // pc stays on the blank word
				fetchIdle <= 1'b1;
			end else begin
				pc <= pc + 1'b1;
			end
		end
	end

	// fetch/decode stage, bubbles once idle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			instrValid <= 1'b0;
		else
			instrValid <= running & ~blank;
	end

	always_ff @(posedge clk) begin
		instr <= fetched;
	end

endmodule

`default_nettype wire

// File: hdl/regFile.sv
/* 32-entry register file, two decode read ports, one host read port
   written from the writeback register, reads are combinational */
`default_nettype none

module regFile (
	input logic clk,
	input logic arstN,
	input logic [cpuPkg::RegAddrWidth-1:0] rsAddr,
	input logic [cpuPkg::RegAddrWidth-1:0] rtAddr,
	output logic [cpuPkg::DataWidth-1:0] rsData,
	output logic [cpuPkg::DataWidth-1:0] rtData,
	input logic [cpuPkg::RegAddrWidth-1:0] hostRegAddr,
	output logic [cpuPkg::DataWidth-1:0] hostRegData,
	resultBus.wb res
);
	import cpuPkg::*;

	logic [DataWidth-1:0] regs [2**RegAddrWidth]; // r0 is writable too

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 2**RegAddrWidth; i++)
				regs[i] <= '0;
		end else if (res.wbValid) begin
			regs[res.wbDest] <= res.wbValue;
		end
	end

	assign rsData = regs[rsAddr];
	assign rtData = regs[rtAddr];
	assign hostRegData = regs[hostRegAddr];

endmodule

`default_nettype wire

// File: verification/apbSlave_checker.sv
/* APB protocol assertions on the cpuTop slave port
   attached to cpuTop by the bind at the end of this file */
`default_nettype none

module apbSlaveChecker (
	input logic clk,
	input logic arstN,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr
);
	int failCount = 0;

	// access phase only after a setup cycle
	penableAfterSetup: assert property (@(posedge clk) disable iff (!arstN)
		$rose(penable) |-> $past(psel && !penable))
		else begin
			$error("penable rose without a setup phase");
			failCount++;
		end

	errOnlyInAccess: assert property (@(posedge clk) disable iff (!arstN)
		pslverr |-> (psel && penable))
		else begin
			$error("pslverr high outside an access phase");
			failCount++;
		end

	readyInAccess: assert property (@(posedge clk) disable iff (!arstN)
		(psel && penable) |-> pready) // no wait states
		else begin
			$error("pready low in an access phase");
			failCount++;
		end

endmodule

bind cpuTop apbSlaveChecker uApbCheck (
	.clk(clk), .arstN(arstN), .psel(psel), .penable(penable),
	.pready(pready), .pslverr(pslverr)
);

`default_nettype wire

// File: include/testProgram.svh
/* test programs for the pipeline, one row per instruction with its destination and the
   value that register holds once the run halts; an all-zero word closes each group */
`ifndef TEST_PROGRAM_SVH
`define TEST_PROGRAM_SVH

typedef struct packed {
	logic [cpuPkg::DataWidth-1:0] word;
	logic [cpuPkg::RegAddrWidth-1:0] dest;
	logic [cpuPkg::DataWidth-1:0] expValue;
} testRowT;

localparam int NumTestRows = 35;

// R-type {op, 0, rs, rt, rd, 0}, I-type {op, 0, rs, rt, const}
localparam testRowT TestTable [NumTestRows] = '{
	// independent operations
	'{{cpuPkg::opAddi, 1'b0, 5'd0, 5'd1, 15'd100}, 5'd1, 32'h0000_0064},
	'{{cpuPkg::opAddi, 1'b0, 5'd0, 5'd2, 15'h7FF9}, 5'd2, 32'hFFFF_FFF9}, // -7
	'{{cpuPkg::opOri, 1'b0, 5'd0, 5'd3, 15'h5A5A}, 5'd3, 32'h0000_5A5A},
	'{{cpuPkg::opOri, 1'b0, 5'd0, 5'd4, 15'h7FFF}, 5'd4, 32'h0000_7FFF},
	'{{cpuPkg::opAdd, 1'b0, 5'd1, 5'd2, 5'd5, 10'd0}, 5'd5, 32'h0000_005D},
	'{{cpuPkg::opSub, 1'b0, 5'd1, 5'd3, 5'd6, 10'd0}, 5'd6, 32'hFFFF_A60A},
	'{{cpuPkg::opAnd, 1'b0, 5'd3, 5'd4, 5'd7, 10'd0}, 5'd7, 32'h0000_5A5A},
	'{{cpuPkg::opOr, 1'b0, 5'd1, 5'd3, 5'd8, 10'd0}, 5'd8, 32'h0000_5A7E},
	'{{cpuPkg::opXor, 1'b0, 5'd2, 5'd4, 5'd9, 10'd0}, 5'd9, 32'hFFFF_8006},
	'{{cpuPkg::opSlt, 1'b0, 5'd2, 5'd1, 5'd10, 10'd0}, 5'd10, 32'h0000_0001},
	'{{cpuPkg::opSlt, 1'b0, 5'd1, 5'd2, 5'd11, 10'd0}, 5'd11, 32'h0000_0000},
	'{32'd0, 5'd0, 32'd0},
	// forwarding chains at distance 1, 2 and 3
	'{{cpuPkg::opAddi, 1'b0, 5'd0, 5'd12, 15'd5}, 5'd12, 32'd5},
	'{{cpuPkg::opAddi, 1'b0, 5'd12, 5'd13, 15'd3}, 5'd13, 32'd8},
	'{{cpuPkg::opAdd, 1'b0, 5'd13, 5'd12, 5'd14, 10'd0}, 5'd14, 32'd13},
	'{{cpuPkg::opSub, 1'b0, 5'd14, 5'd12, 5'd15, 10'd0}, 5'd15, 32'd8},
	'{{cpuPkg::opOr, 1'b0, 5'd14, 5'd12, 5'd16, 10'd0}, 5'd16, 32'd13},
	'{{cpuPkg::opAdd, 1'b0, 5'd16, 5'd15, 5'd17, 10'd0}, 5'd17, 32'd21},
	'{{cpuPkg::opAddi, 1'b0, 5'd16, 5'd18, 15'd1000}, 5'd18, 32'd1013},
	'{{cpuPkg::opSub, 1'b0, 5'd18, 5'd17, 5'd19, 10'd0}, 5'd19, 32'd992},
	'{{cpuPkg::opAdd, 1'b0, 5'd17, 5'd19, 5'd20, 10'd0}, 5'd20, 32'd1013},
	'{{cpuPkg::opAddi, 1'b0, 5'd0, 5'd21, 15'd1}, 5'd21, 32'd3}, // overwritten next
	'{{cpuPkg::opAddi, 1'b0, 5'd21, 5'd21, 15'd2}, 5'd21, 32'd3},
	'{{cpuPkg::opAdd, 1'b0, 5'd21, 5'd21, 5'd22, 10'd0}, 5'd22, 32'd6}, // execute beats wb
	'{32'd0, 5'd0, 32'd0},
	// shifts and lui
	'{{cpuPkg::opOri, 1'b0, 5'd0, 5'd1, 15'h1234}, 5'd1, 32'h0000_1234},
	'{{cpuPkg::opShl, 1'b0, 5'd4, 5'd1, 5'd2, 10'd0}, 5'd2, 32'h0001_2340},
	'{{cpuPkg::opShr, 1'b0, 5'd3, 5'd1, 5'd3, 10'd0}, 5'd3, 32'h0000_0246},
	'{{cpuPkg::opShl, 1'b0, 5'd19, 5'd1, 5'd4, 10'd0}, 5'd4, 32'h91A0_0000},
	'{{cpuPkg::opShr, 1'b0, 5'd28, 5'd4, 5'd5, 10'd0}, 5'd5, 32'h0000_0009},
	'{{cpuPkg::opLui, 1'b0, 5'd0, 5'd6, 15'h2468}, 5'd6, 32'h48D0_0000},
	'{{cpuPkg::opOri, 1'b0, 5'd6, 5'd7, 15'h1357}, 5'd7, 32'h48D0_1357},
	'{{cpuPkg::opLui, 1'b0, 5'd0, 5'd8, 15'h7FFF}, 5'd8, 32'hFFFE_0000},
	'{{cpuPkg::opOri, 1'b0, 5'd8, 5'd9, 15'h7FFF}, 5'd9, 32'hFFFE_7FFF},
	'{32'd0, 5'd0, 32'd0}
};

`endif

// File: verification/cpuTb.sv
/* testbench for cpuTop: loads each table group over APB, runs it, polls STATUS and
   reads back the destination registers; also covers reset, bus errors and random constants */
`default_nettype none

module cpuTb;
	import cpuPkg::*;

	`include "testProgram.svh"

	localparam int RandRows = 7;
	localparam int TotalRows = NumTestRows + 12 + RandRows + 8; // replay and reset checks too
	localparam int CycleLimit = TotalRows * (2**PcWidth + PipeDepth + 20);

	logic clk;
	logic arstN;
	logic [ApbAddrWidth-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [DataWidth-1:0] pwdata;
	logic [DataWidth-1:0] prdata;
	logic pready;
	logic pslverr;

	int cycleCount = 0;
	int errCount = 0;
	int errAtStart = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	logic [DataWidth-1:0] progWord [$];
	logic [RegAddrWidth-1:0] progDest [$];
	logic [DataWidth-1:0] progExp [$];

	cpuTop u_dut (
		.clk(clk), .arstN(arstN), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("error: run stopped after %0d cycles, a program never halted", cycleCount);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic logic [ApbAddrWidth-1:0] imemWordAddr(input int idx);
		return ImemBase | {2'b00, idx[PcWidth-1:0], 2'b00};
	endfunction

	function automatic logic [ApbAddrWidth-1:0] regWordAddr(input logic [RegAddrWidth-1:0] r);
		return RegBase | {2'b00, r, 2'b00};
	endfunction

	function automatic logic [31:0] encodeImm(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [14:0] c);
		return {op, 1'b0, rs, rt, c};
	endfunction

	function automatic logic [31:0] encodeReg(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {op, 1'b0, rs, rt, rd, 10'd0};
	endfunction

	function automatic logic [31:0] signExtend(input logic [14:0] c);
		return {{17{c[14]}}, c};
	endfunction

	// setup, access, then release on the following edge
	task automatic apbWrite(input logic [ApbAddrWidth-1:0] addr, input logic [31:0] data,
		output logic err);
		@(posedge clk);
		paddr <= addr;
		pwdata <= data;
		pwrite <= 1'b1;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		err = pslverr;
		checkValue("pready", 32'(pready), 32'd1);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apbRead(input logic [ApbAddrWidth-1:0] addr, output logic [31:0] data,
		output logic err);
		@(posedge clk);
		paddr <= addr;
		pwrite <= 1'b0;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk); // mid-cycle, away from the edge
		data = prdata;
		err = pslverr;
		checkValue("pready", 32'(pready), 32'd1);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch %s: got 0x%h, expected 0x%h", name, got, expected);
			errCount++;
		end
	endtask

	task automatic finishTest(input string name);
		if (errCount == errAtStart) begin
			testsPassed++;
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: failed with %0d errors", name, errCount - errAtStart);
		end
		errAtStart = errCount;
	endtask

	// copies one table group, up to and including its blank word
	task automatic loadTableGroup(input int first, output int next);
		int idx;
		idx = first;
		progWord.delete();
		progDest.delete();
		progExp.delete();
		while (TestTable[idx].word != '0) begin
			progWord.push_back(TestTable[idx].word);
			progDest.push_back(TestTable[idx].dest);
			progExp.push_back(TestTable[idx].expValue);
			idx++;
		end
		progWord.push_back('0);
		progDest.push_back('0);
		progExp.push_back('0);
		next = idx + 1;
	endtask

	// addi/xor chain on random constants, r0 is never written so it stays zero
	task automatic buildRandomGroup();
		logic [14:0] c [4];
		logic [31:0] r23, r24, r25, r26, r27, r28;
		foreach (c[k])
			c[k] = 15'($urandom);
		r23 = signExtend(c[0]);
		r24 = r23 + signExtend(c[1]);
		r25 = r23 ^ r24;
		r26 = r25 + signExtend(c[2]);
		r27 = r26 ^ r23;
		r28 = r27 + signExtend(c[3]);
		progWord = '{encodeImm(opAddi, 5'd0, 5'd23, c[0]), encodeImm(opAddi, 5'd23, 5'd24, c[1]),
			encodeReg(opXor, 5'd23, 5'd24, 5'd25), encodeImm(opAddi, 5'd25, 5'd26, c[2]),
			encodeReg(opXor, 5'd26, 5'd23, 5'd27), encodeImm(opAddi, 5'd27, 5'd28, c[3]), 32'd0};
		progDest = '{5'd23, 5'd24, 5'd25, 5'd26, 5'd27, 5'd28, 5'd0};
		progExp = '{r23, r24, r25, r26, r27, r28, 32'd0};
	endtask

	task automatic runProgram(input bit intrude);
		logic err;
		logic [31:0] data;
		for (int i = 0; i < progWord.size(); i++) begin
			apbWrite(imemWordAddr(i), progWord[i], err);
			checkValue("pslverr on load", 32'(err), 32'd0);
		end
		apbWrite(CtrlAddr, 32'd1, err);
		checkValue("pslverr on start", 32'(err), 32'd0);
		if (intrude) begin
			apbRead(StatusAddr, data, err);
			checkValue("status running", 32'(data[0]), 32'd1);
			apbWrite(imemWordAddr(8), 32'd0, err); // a blank here would cut the program short
			checkValue("pslverr on busy load", 32'(err), 32'd1);
		end
		do
			apbRead(StatusAddr, data, err);
		while (!data[1]);
		for (int i = 0; i < progWord.size(); i++) begin
			if (progWord[i] != '0) begin
				apbRead(regWordAddr(progDest[i]), data, err);
				checkValue($sformatf("r%0d", progDest[i]), data, progExp[i]);
			end
		end
	endtask

	initial begin
		logic err;
		logic [31:0] data;
		int first;
		int next;
		string groupNames [3];
		groupNames = '{"independent ops", "forwarding", "shifts and lui"};
		void'($urandom(32'hba45));
		arstN = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		repeat (16) @(posedge clk);
		arstN <= 1'b1;

		apbRead(StatusAddr, data, err);
		checkValue("status", data, 32'd0);
		checkValue("pslverr on status read", 32'(err), 32'd0);
		apbRead(regWordAddr(5'd0), data, err);
		checkValue("r0", data, 32'd0);
		apbRead(regWordAddr(5'd31), data, err);
		checkValue("r31", data, 32'd0);
		apbWrite(RegBase, 32'hdead_beef, err);
		checkValue("pslverr on register write", 32'(err), 32'd1);
		apbWrite(9'h1F0, 32'h1, err); // outside the map
		checkValue("pslverr on unmapped write", 32'(err), 32'd1);
		finishTest("reset state");

		first = 0;
		for (int g = 0; g < 3; g++) begin
			loadTableGroup(first, next);
			runProgram(1'b0);
			finishTest(groupNames[g]);
			first = next;
		end

		// r1..r9 now hold shift values, so a lost word shows up as stale results
		loadTableGroup(0, next);
		runProgram(1'b1);
		finishTest("write while running");

		buildRandomGroup();
		runProgram(1'b0);
		checkValue("apb assertion failures", 32'(u_dut.uApbCheck.failCount), 32'd0);
		finishTest("random constants");

		$display("tests passed: %0d, failed: %0d", testsPassed, testsFailed);
		if (testsFailed == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
